// File: design/pdp8_word_pkg.sv
package pdp8_word_pkg;

  // Machine word, bit 11 is the PDP-8 bit 0
  typedef logic [11:0] word_t;

  // Memory field, the top three bits of an extended address
  typedef logic [2:0] field_t;

  // Field and word address together
  typedef logic [14:0] ext_addr_t;

  // Page number, the top five bits of a word address
  typedef logic [4:0] page_t;

  // Major opcode in instruction bits 11:9
  typedef enum logic [2:0] {
    OP_AND = 3'o0,  // Logical and
    OP_TAD = 3'o1,  // Two's complement add
    OP_ISZ = 3'o2,  // Increment and skip if zero
    OP_DCA = 3'o3,  // Deposit and clear ac
    OP_JMS = 3'o4,  // Jump to subroutine
    OP_JMP = 3'o5,  // Jump
    OP_IOT = 3'o6,  // Device transfer
    OP_OPR = 3'o7   // Operate
  } opcode_t;

  localparam word_t NOP_WORD = 12'o7000;  // Group-1 OPR with no bits set
  localparam word_t JMS_ZERO = 12'o4000;  // Forced on interrupt entry
  localparam word_t WORD_ONES = 12'o7777;

  // Locations 0010 to 0017 increment before use as a pointer
  localparam word_t AUTO_INDEX_BASE = 12'o0010;

endpackage

// File: design/cpu_state_pkg.sv
package cpu_state_pkg;

  import pdp8_word_pkg::word_t;

  // Every group runs X0, XW, X1, X2, X3 with one clock per state
  typedef enum logic [4:0] {
    F0,  // Fetch, address on the bus
    FW,  // Fetch, instruction returns
    F1,
    F2,
    F3,  // Fetch, operand address formed
    D0,  // Defer, pointer address on the bus
    DW,
    D1,  // Auto-index write back
    D2,
    D3,
    E0,  // Execute, operand address on the bus
    EW,
    E1,  // Execute write slot
    E2,
    E3,
    H0,  // Panel cycle while halted
    HW,
    H1,
    H2,
    H3
  } major_state_t;

  // Front panel switches and command levels
  typedef struct packed {
    word_t sr;         // Switch register
    logic  sw;         // Forces load-address to 7777
    logic  addr_load;
    logic  deposit;
    logic  examine;
  } panel_ctl_t;

endpackage

// File: design/core_memory.sv
`timescale 1ns/1ps

module core_memory
  import pdp8_word_pkg::*;
#(
  parameter int MEM_ADDR_BITS = 15
) (
  input  logic      clk,
  input  ext_addr_t addr,
  input  word_t     wdata,
  input  logic      we,
  output word_t     rdata
);

  localparam int DEPTH = 1 << MEM_ADDR_BITS;

  word_t mem [DEPTH];
  logic [MEM_ADDR_BITS-1:0] index;

  // High field bits drop out when the memory is smaller than 32K
  assign index = addr[MEM_ADDR_BITS-1:0];

  always_ff @(posedge clk) begin
    if (we) begin
      mem[index] <= wdata;
    end
    rdata <= mem[index];  // Old word on a same-cycle write
  end

endmodule

// File: design/operate_skip.sv
`timescale 1ns/1ps

module operate_skip
  import pdp8_word_pkg::*;
(
  input  word_t instruction,
  input  word_t ac,
  input  logic  link,
  output logic  skip
);

  logic group2;
  logic sma;
  logic sza;
  logic snl;
  logic reverse;
  logic any_cond;

  // Group 2 is 7xxx with bit 8 set and bit 0 clear
  assign group2 = (instruction[11:9] == OP_OPR) && instruction[8] && !instruction[0];

  assign sma = instruction[6];
  assign sza = instruction[5];
  assign snl = instruction[4];
  assign reverse = instruction[3];  // SPA, SNA, SZL sense

  always_comb begin
    any_cond = 1'b0;
    if (sma && ac[11]) begin
      any_cond = 1'b1;  // Negative ac
    end
    if (sza && (ac == '0)) begin
      any_cond = 1'b1;
    end
    if (snl && link) begin
      any_cond = 1'b1;
    end
  end

  // With no condition bits and reverse set this is SKP
  assign skip = group2 ? (any_cond ^ reverse) : 1'b0;

endmodule

// File: design/major_state_sequencer.sv
`timescale 1ns/1ps

module major_state_sequencer
  import pdp8_word_pkg::*, cpu_state_pkg::*;
(
  input  logic         clk,
  input  logic         reset,
  input  logic         run,
  input  logic         int_req,
  input  word_t        instruction,
  output major_state_t state,
  output logic         int_in_prog
);

  opcode_t      opcode;
  logic         needs_defer;
  logic         needs_exec;
  logic         take_int;
  major_state_t idle_group;
  major_state_t next_state;
  logic         next_int;

  assign opcode = opcode_t'(instruction[11:9]);
  assign needs_defer = (opcode <= OP_JMP) && instruction[8];  // Indirect memory reference
  assign needs_exec = (opcode <= OP_JMS);
  assign take_int = int_req && run && !int_in_prog;  // No nesting inside an entry
  assign idle_group = run ? F0 : H0;

  always_comb begin
    next_state = state;
    next_int = int_in_prog;
    case (state)
      F0: next_state = FW;
      FW: next_state = F1;
      F1: next_state = F2;
      F2: next_state = F3;
      F3: begin
        if (take_int && !needs_defer && !needs_exec) begin
          next_state = E0;  // Forced JMS 0
          next_int = 1'b1;
        end else if (needs_defer) begin
          next_state = D0;
        end else if (needs_exec) begin
          next_state = E0;
        end else begin
          next_state = idle_group;
        end
      end
      D0: next_state = DW;
      DW: next_state = D1;
      D1: next_state = D2;
      D2: next_state = D3;
      D3: next_state = needs_exec ? E0 : idle_group;
      E0: next_state = EW;
      EW: next_state = E1;
      E1: next_state = E2;
      E2: next_state = E3;
      E3: begin
        next_int = 1'b0;  // Entry ends here
        if (take_int) begin
          next_state = E0;
          next_int = 1'b1;
        end else begin
          next_state = idle_group;
        end
      end
      H0: next_state = HW;
      HW: next_state = H1;
      H1: next_state = H2;
      H2: next_state = H3;
      H3: next_state = idle_group;
      default: next_state = H0;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= H0;
      int_in_prog <= 1'b0;
    end else begin
      state <= next_state;
      int_in_prog <= next_int;
    end
  end

  // An interrupt entry never passes through defer
  int_not_in_defer: assert property (
    @(posedge clk) disable iff (reset)
    (state inside {D0, DW, D1, D2, D3}) |-> !int_in_prog
  ) else $error("int_in_prog high in defer state %s", state.name());

endmodule

// File: design/memory_address.sv
`timescale 1ns/1ps

module memory_address
  import pdp8_word_pkg::*, cpu_state_pkg::*;
(
  input  logic         clk,
  input  logic         reset,
  input  major_state_t state,
  input  panel_ctl_t   panel,
  input  word_t        ac,
  input  logic         skip,
  input  logic         int_in_prog,
  input  field_t       if_field,
  input  field_t       df_field,
  input  word_t        mem_rdata,
  output word_t        mem_wdata,
  output logic         mem_we,
  output word_t        instruction,
  output word_t        mdout,
  output ext_addr_t    eaddr
);

  word_t   pc;
  word_t   next_pc;
  word_t   skip_pc;
  word_t   idx_tmp;
  page_t   current_page;
  logic    index;
  logic    take_skip;
  opcode_t opcode;
  word_t   page_addr;
  word_t   pointer;
  field_t  ret_field;

  assign opcode = opcode_t'(instruction[11:9]);

  // Bit 7 picks the current page, otherwise page 0
  assign page_addr = instruction[7] ? {current_page, instruction[6:0]}
                                    : {5'b00000, instruction[6:0]};

  assign pointer = index ? idx_tmp : mdout;
  assign ret_field = int_in_prog ? field_t'(3'b000) : if_field;  // Interrupt runs in field 0

  // Write data and enable for the X1 slot
  always_comb begin
    mem_wdata = mdout;
    mem_we = 1'b0;
    case (state)
      D1: begin
        mem_wdata = mdout + 12'd1;  // Auto-index bump
        mem_we = index;
      end
      E1: begin
        case (opcode)
          OP_ISZ: begin
            mem_wdata = mdout + 12'd1;
            mem_we = 1'b1;
          end
          OP_DCA: begin
            mem_wdata = ac;
            mem_we = 1'b1;
          end
          OP_JMS: begin
            mem_wdata = next_pc;  // Return address, also on interrupt
            mem_we = 1'b1;
          end
          default: ;
        endcase
      end
      H1: begin
        mem_wdata = panel.sr;
        mem_we = panel.deposit && !panel.addr_load;
      end
      default: ;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      eaddr <= '0;
      instruction <= NOP_WORD;
      index <= 1'b0;
      take_skip <= 1'b0;
    end else begin
      case (state)
        F0: pc <= eaddr[11:0];
        FW: begin
          instruction <= mem_rdata;
          mdout <= mem_rdata;
        end
        F1: begin
          current_page <= pc[11:7];
          next_pc <= pc + 12'd1;
          skip_pc <= pc + 12'd2;
        end
        F2: take_skip <= skip;
        F3: begin
          if (opcode == OP_IOT || opcode == OP_OPR) begin
            if (take_skip) begin
              next_pc <= skip_pc;
              eaddr <= {if_field, skip_pc};
            end else begin
              eaddr <= {if_field, next_pc};
            end
          end else begin
            eaddr <= {if_field, page_addr};  // Operand or pointer location
            if (opcode == OP_JMP) begin
              next_pc <= page_addr;
            end
          end
        end
        D0: index <= (eaddr[11:3] == AUTO_INDEX_BASE[11:3]);
        DW: mdout <= mem_rdata;  // Pointer word
        D1: begin
          if (index) begin
            idx_tmp <= mdout + 12'd1;
          end
        end
        D3: begin
          index <= 1'b0;
          case (opcode)
            OP_JMP: begin
              next_pc <= pointer;
              eaddr <= {if_field, pointer};
            end
            OP_JMS: eaddr <= {if_field, pointer};
            default: eaddr <= {df_field, pointer};  // Data field for operands
          endcase
        end
        EW: begin
          mdout <= mem_rdata;
          if (int_in_prog) begin
            instruction <= JMS_ZERO;  // Entry behaves as JMS 0
            eaddr <= '0;
          end
        end
        E1: begin
          if (opcode == OP_ISZ && mdout == WORD_ONES) begin
            next_pc <= skip_pc;  // Count wrapped to zero
          end
        end
        E2: begin
          if (opcode == OP_JMS) begin
            next_pc <= eaddr[11:0] + 12'd1;
          end
        end
        E3: eaddr <= {ret_field, next_pc};
        HW: mdout <= mem_rdata;
        H1: begin
          if (panel.addr_load) begin
            eaddr[11:0] <= panel.sw ? WORD_ONES : panel.sr;
          end
        end
        H2: begin
          if (!panel.addr_load && (panel.deposit || panel.examine)) begin
            eaddr[11:0] <= eaddr[11:0] + 12'd1;  // Post-increment
          end
        end
        default: ;
      endcase
    end
  end

  // Writes only in the defer, execute and deposit slots
  we_in_write_slot: assert property (
    @(posedge clk) disable iff (reset)
    mem_we |-> (state inside {D1, E1} || (state == H1 && panel.deposit))
  ) else $error("mem_we high in state %s", state.name());

endmodule

// File: design/memory_subsystem.sv
`timescale 1ns/1ps

module memory_subsystem
  import pdp8_word_pkg::*, cpu_state_pkg::*;
#(
  parameter int MEM_ADDR_BITS = 15
) (
  input  logic         clk,
  input  logic         reset,
  input  panel_ctl_t   panel,
  input  logic         run,
  input  word_t        ac,
  input  logic         link,
  input  field_t       if_field,
  input  field_t       df_field,
  input  logic         int_req,
  output major_state_t state,
  output word_t        instruction,
  output word_t        mdout,
  output ext_addr_t    eaddr,
  output logic         int_in_prog
);

  logic  skip;
  logic  mem_we;
  word_t mem_wdata;
  word_t mem_rdata;

  major_state_sequencer major_state_sequencer_i (
    .clk         (clk),
    .reset       (reset),
    .run         (run),
    .int_req     (int_req),
    .instruction (instruction),
    .state       (state),
    .int_in_prog (int_in_prog)
  );

  operate_skip operate_skip_i (
    .instruction (instruction),
    .ac          (ac),
    .link        (link),
    .skip        (skip)
  );

  memory_address memory_address_i (
    .clk         (clk),
    .reset       (reset),
    .state       (state),
    .panel       (panel),
    .ac          (ac),
    .skip        (skip),
    .int_in_prog (int_in_prog),
    .if_field    (if_field),
    .df_field    (df_field),
    .mem_rdata   (mem_rdata),
    .mem_wdata   (mem_wdata),
    .mem_we      (mem_we),
    .instruction (instruction),
    .mdout       (mdout),
    .eaddr       (eaddr)
  );

  core_memory #(
    .MEM_ADDR_BITS (MEM_ADDR_BITS)
  ) core_memory_i (
    .clk   (clk),
    .addr  (eaddr),
    .wdata (mem_wdata),
    .we    (mem_we),
    .rdata (mem_rdata)
  );

endmodule

// File: tests/memory_subsystem_tb.sv
`timescale 1ns/1ps

module memory_subsystem_tb
  import pdp8_word_pkg::*, cpu_state_pkg::*;
();

  localparam int WAIT_LIMIT = 200;  // Cycles before any wait gives up

  logic         clk;
  logic         reset;
  panel_ctl_t   panel;
  logic         run;
  word_t        ac;
  logic         link;
  field_t       if_field;
  field_t       df_field;
  logic         int_req;
  major_state_t state;
  word_t        instruction;
  word_t        mdout;
  ext_addr_t    eaddr;
  logic         int_in_prog;

  word_t     mem_model [4096];  // Expected field 0 contents
  word_t     panel_addr;        // Expected panel address
  string     test_name;
  logic      check_addr;
  logic      check_data;
  logic      check_instr;
  logic      check_int;
  ext_addr_t exp_eaddr;
  word_t     exp_mdout;
  word_t     exp_instr;
  logic      exp_int;

  memory_subsystem memory_subsystem_i (
    .clk         (clk),
    .reset       (reset),
    .panel       (panel),
    .run         (run),
    .ac          (ac),
    .link        (link),
    .if_field    (if_field),
    .df_field    (df_field),
    .int_req     (int_req),
    .state       (state),
    .instruction (instruction),
    .mdout       (mdout),
    .eaddr       (eaddr),
    .int_in_prog (int_in_prog)
  );

  always #20 clk = ~clk;

  task automatic report_mismatch(input string what, input logic [14:0] expected,
                                 input logic [14:0] actual);
    $display("Fail %s: %s expected %o, actual %o", test_name, what, expected, actual);
    $display("=== FAIL ===");
    $fatal(1, "Output mismatch");
  endtask

  eaddr_matches: assert property (
    @(posedge clk) disable iff (reset) check_addr |-> (eaddr == exp_eaddr)
  ) else report_mismatch("eaddr", $sampled(exp_eaddr), $sampled(eaddr));

  mdout_matches: assert property (
    @(posedge clk) disable iff (reset) check_data |-> (mdout == exp_mdout)
  ) else report_mismatch("mdout", 15'($sampled(exp_mdout)), 15'($sampled(mdout)));

  instruction_matches: assert property (
    @(posedge clk) disable iff (reset) check_instr |-> (instruction == exp_instr)
  ) else report_mismatch("instruction", 15'($sampled(exp_instr)), 15'($sampled(instruction)));

  int_in_prog_matches: assert property (
    @(posedge clk) disable iff (reset) check_int |-> (int_in_prog == exp_int)
  ) else report_mismatch("int_in_prog", 15'($sampled(exp_int)), 15'($sampled(int_in_prog)));

  // Memory-reference word for a target on page 0 or the current page
  function automatic word_t mem_ref(input opcode_t op, input logic indirect,
                                    input word_t target);
    logic cur_page;
    cur_page = (target[11:7] != 5'd0);
    return {op, indirect, cur_page, target[6:0]};
  endfunction

  task automatic wait_for_state(input major_state_t target);
    int cycles;
    cycles = 0;
    do begin
      @(posedge clk);
      #2;  // Outputs settled, inputs change here
      cycles++;
      if (cycles > WAIT_LIMIT) begin
        $display("Timed out in %s waiting for state %s", test_name, target.name());
        $display("=== FAIL ===");
        $fatal(1, "Wait timeout");
      end
    end while (state != target);
  endtask

  // Arms the checks for the coming edge, field 0 throughout
  task automatic expect_values(input word_t addr, input logic with_data, input word_t data);
    exp_eaddr = {3'b000, addr};
    exp_mdout = data;
    check_addr = 1'b1;
    check_data = with_data;
    @(posedge clk);
    #2;
    check_addr = 1'b0;
    check_data = 1'b0;
  endtask

  task automatic panel_cycle(input word_t sr, input logic sw, input logic load,
                             input logic dep, input logic exam);
    wait_for_state(H0);
    panel = {sr, sw, load, dep, exam};
    wait_for_state(H3);  // Nothing is sampled in H3
    panel = '0;
  endtask

  task automatic load_address(input word_t addr);
    panel_cycle(addr, 1'b0, 1'b1, 1'b0, 1'b0);
    panel_addr = addr;
    expect_values(panel_addr, 1'b0, '0);
  endtask

  task automatic deposit_word(input word_t data);
    panel_cycle(data, 1'b0, 1'b0, 1'b1, 1'b0);
    mem_model[panel_addr] = data;
    panel_addr = panel_addr + 12'd1;  // Post-increment
    expect_values(panel_addr, 1'b0, '0);
  endtask

  task automatic examine_word();
    word_t expected;
    expected = mem_model[panel_addr];
    panel_cycle('0, 1'b0, 1'b0, 1'b0, 1'b1);
    panel_addr = panel_addr + 12'd1;
    expect_values(panel_addr, 1'b1, expected);
  endtask

  task automatic poke(input word_t addr, input word_t data);
    load_address(addr);
    deposit_word(data);
  endtask

  task automatic run_program(input word_t start);
    load_address(start);
    run = 1'b1;  // Fetch starts after this panel cycle
  endtask

  task automatic expect_fetch(input word_t pc);
    wait_for_state(F1);  // Fetch address still on eaddr
    exp_instr = mem_model[pc];
    exp_int = 1'b0;  // Ordinary fetch, no entry in progress
    check_instr = 1'b1;
    check_int = 1'b1;
    expect_values(pc, 1'b0, '0);
    check_instr = 1'b0;
    check_int = 1'b0;
  endtask

  initial begin
    int    i;
    word_t value;
    clk = 1'b0;
    reset = 1'b1;
    panel = '0;
    run = 1'b0;
    ac = '0;
    link = 1'b0;
    if_field = '0;
    df_field = '0;
    int_req = 1'b0;
    check_addr = 1'b0;
    check_data = 1'b0;
    check_instr = 1'b0;
    check_int = 1'b0;
    exp_eaddr = '0;
    exp_mdout = '0;
    exp_instr = '0;
    exp_int = 1'b0;
    panel_addr = '0;
    test_name = "reset";
    void'($urandom(32'h2809_2662));
    repeat (10) @(posedge clk);
    #2;
    reset = 1'b0;

    test_name = "load_address";
    value = word_t'($urandom);
    load_address(value);
    panel_cycle(value, 1'b1, 1'b1, 1'b0, 1'b0);
    expect_values(WORD_ONES, 1'b0, '0);  // sw overrides sr

    test_name = "deposit_examine";
    load_address(12'o1000);
    for (i = 0; i < 8; i++) begin
      deposit_word(word_t'($urandom));
    end
    load_address(12'o1000);
    for (i = 0; i < 8; i++) begin
      examine_word();
    end

    test_name = "jmp_dca_isz";
    poke(12'o0200, mem_ref(OP_JMP, 1'b0, 12'o0210));
    poke(12'o0210, mem_ref(OP_DCA, 1'b0, 12'o0250));
    poke(12'o0211, mem_ref(OP_ISZ, 1'b0, 12'o0251));
    poke(12'o0212, mem_ref(OP_JMP, 1'b0, 12'o0212));  // Skipped by the ISZ
    poke(12'o0213, mem_ref(OP_JMP, 1'b0, 12'o0213));
    poke(12'o0251, WORD_ONES);
    ac = word_t'($urandom);
    run_program(12'o0200);
    expect_fetch(12'o0200);
    expect_fetch(12'o0210);
    expect_fetch(12'o0211);
    expect_fetch(12'o0213);
    run = 1'b0;
    mem_model[12'o0250] = ac;
    mem_model[12'o0251] = mem_model[12'o0251] + 12'd1;  // 7777 wraps to 0
    load_address(12'o0250);
    examine_word();
    examine_word();

    test_name = "auto_index";
    poke(12'o0010, 12'o1077);
    poke(12'o1100, word_t'($urandom));
    poke(12'o0400, mem_ref(OP_TAD, 1'b1, 12'o0010));
    poke(12'o0401, mem_ref(OP_JMP, 1'b0, 12'o0401));
    run_program(12'o0400);
    wait_for_state(E1);
    mem_model[12'o0010] = mem_model[12'o0010] + 12'd1;  // Bumped before use
    expect_values(mem_model[12'o0010], 1'b1, mem_model[mem_model[12'o0010]]);
    expect_fetch(12'o0401);
    run = 1'b0;
    load_address(12'o0010);
    examine_word();

    test_name = "sza_skip";
    poke(12'o0600, 12'o7440);  // SZA
    poke(12'o0601, mem_ref(OP_JMP, 1'b0, 12'o0601));
    poke(12'o0602, mem_ref(OP_JMP, 1'b0, 12'o0602));
    ac = '0;
    run_program(12'o0600);
    expect_fetch(12'o0600);
    expect_fetch(12'o0602);
    run = 1'b0;
    ac = word_t'($urandom) | 12'o0001;  // Any nonzero value
    run_program(12'o0600);
    expect_fetch(12'o0600);
    expect_fetch(12'o0601);
    run = 1'b0;

    test_name = "interrupt";
    poke(12'o0001, mem_ref(OP_JMP, 1'b0, 12'o0001));  // Handler parks here
    poke(12'o0300, NOP_WORD);
    poke(12'o0301, mem_ref(OP_JMP, 1'b0, 12'o0300));
    run_program(12'o0300);
    wait_for_state(F0);
    int_req = 1'b1;  // Taken at the end of this NOP
    if_field = 3'o1;  // Handler still starts in field 0
    wait_for_state(E0);
    int_req = 1'b0;
    exp_int = 1'b1;
    check_int = 1'b1;
    wait_for_state(E3);
    check_int = 1'b0;
    mem_model[12'o0000] = 12'o0301;  // Return PC after the NOP
    expect_fetch(12'o0001);
    run = 1'b0;
    if_field = '0;
    load_address(12'o0000);
    examine_word();

    $display("=== PASS ===");
    $finish;
  end

endmodule

// File: src.f
design/pdp8_word_pkg.sv
design/cpu_state_pkg.sv
design/core_memory.sv
design/operate_skip.sv
design/major_state_sequencer.sv
design/memory_address.sv
design/memory_subsystem.sv
tests/memory_subsystem_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
set -u

cd "$(dirname "$0")" || exit 1

build_dir=obj_dir
log_file=sim.log

verilator --binary --assert --timescale 1ns/1ps \
  --top-module memory_subsystem_tb -f src.f -Mdir "$build_dir"
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

"./$build_dir/Vmemory_subsystem_tb" > "$log_file" 2>&1
run_status=$?
cat "$log_file"

if grep -q "=== FAIL ===" "$log_file"; then
  echo "Testbench reported a failure, see $log_file"
  exit 1
fi
if [ "$run_status" -ne 0 ]; then
  echo "Simulation exited with status $run_status"
  exit 1
fi

echo "No failure found in $log_file"
exit 0
